/* verilog/sys_cfg.svh */
/*
 * Shared constants for the system top.
 * Command codes are the 8-bit values found in the first word of an HPS frame.
 * Attenuation word: bit 4 mutes, bits 3..0 give the right shift.
 * Sync length counters saturate at their maximum value.
 */
`ifndef SYS_CFG_SVH
`define SYS_CFG_SVH

// Command codes
`define SYS_CMD_CFG 8'h01
`define SYS_CMD_LED 8'h25
`define SYS_CMD_VOL 8'h26

// Data path widths
`define SYS_IO_W 16
`define SYS_AUDIO_W 16
`define SYS_VOL_W 5
`define SYS_SYNC_CNT_W 16

// Composite sync enable within the config word
`define SYS_CSYNC_BIT 3

`endif

/* verilog/sys_pkg.sv */
/*
 * Types shared by the system top modules.
 * One HPS data word is read either as the config word or as the LED word,
 * depending on the command of the frame.
 */
`include "sys_cfg.svh"

package sys_pkg;

	localparam int AUDIO_W   = `SYS_AUDIO_W;
	localparam int RGB_IN_W  = 8;
	localparam int RGB_OUT_W = 6;

	// ==============================
	// Config view of an io word
	// ==============================
	typedef struct packed {
		logic [7:0]                  rsvd_hi;
		logic                        dvi_mode;
		logic                        audio_96k;
		logic                        ypbpr_en;
		logic                        rsvd_4;
		logic                        csync;
		logic                        vga_scaler;
		logic [`SYS_CSYNC_BIT-2:0]   rsvd_lo;
	} cfg_word_t;

	// ==============================
	// LED view of an io word
	// ==============================
	typedef struct packed {
		logic [`SYS_IO_W/2-1:0] overtake;
		logic [`SYS_IO_W/2-1:0] state;
	} led_word_t;

	// Same bits, decoded per command
	typedef union packed {
		cfg_word_t cfg;
		led_word_t led;
	} io_word_u;

endpackage

/* verilog/hps_io_ctrl.sv */
/*
 * HPS command port and settings registers.
 * io_clk is a level from the host; it is resynchronized here. The host must
 * hold io_din stable until io_ack is high and must not raise io_clk again
 * before io_ack is low. There is no wait signal. Every strobe is accepted.
 * A low io_uio ends the frame; the next word is taken as a command.
 */
`include "sys_cfg.svh"

module hps_io_ctrl (
	input  logic                  clk_sys,
	input  logic                  resetd,
	input  logic                  i_io_clk,
	input  logic                  i_io_uio,
	input  logic [`SYS_IO_W-1:0]  i_io_din,
	input  logic                  i_led_user,
	input  logic [1:0]            i_led_power,
	input  logic [1:0]            i_led_disk,
	output logic                  o_io_ack,
	output logic [`SYS_VOL_W-1:0] o_vol_att,
	output logic                  o_csync,
	output logic [7:0]            o_led
);
	import sys_pkg::*;

	logic                  io_clk_m;
	logic                  io_clk_s;
	logic                  rack;
	logic                  io_strobe;
	logic                  has_cmd;
	logic [7:0]            cmd;
	io_word_u              io_word;
	cfg_word_t             cfg;
	led_word_t             led_ovr;
	logic [`SYS_VOL_W-1:0] vol_att;
	logic                  led_p;
	logic                  led_d;
	logic [7:0]            led_status;

	// ==============================
	// Strobe and acknowledge
	// ==============================
	assign io_strobe = io_clk_s & ~rack;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			io_clk_m <= 1'b0;
			io_clk_s <= 1'b0;
			rack     <= 1'b0;
			o_io_ack <= 1'b0;
		end else begin
			io_clk_m <= i_io_clk;
			io_clk_s <= io_clk_m;
			rack     <= io_clk_s;
			o_io_ack <= rack;
		end
	end

	// ==============================
	// Frame and command decode
	// ==============================
	assign io_word = i_io_din;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			has_cmd <= 1'b0;
			cfg     <= '0;
			led_ovr <= '0;
			vol_att <= '0;
		end else if (!i_io_uio) begin
			has_cmd <= 1'b0;
		end else if (io_strobe) begin
			if (!has_cmd) begin
				has_cmd <= 1'b1;
			end else begin
				// Data word decoded by the frame command
				case (cmd)
					`SYS_CMD_CFG: cfg     <= io_word.cfg;
					`SYS_CMD_LED: led_ovr <= io_word.led;
					`SYS_CMD_VOL: vol_att <= io_word[`SYS_VOL_W-1:0];
					default: ;
				endcase
			end
		end
	end

	// Command byte of the current frame
	always_ff @(posedge clk_sys) begin
		if (i_io_uio && io_strobe && !has_cmd)
			cmd <= i_io_din[7:0];
	end

	assign o_vol_att = vol_att;
	assign o_csync   = cfg.csync;

	// Board LEDs with override bits over status
	assign led_p      = i_led_power[1] ? ~i_led_power[0] : 1'b0;
	assign led_d      = i_led_disk[1] ? ~i_led_disk[0] : 1'b0;
	assign led_status = {3'b000, ~led_p, 1'b0, ~led_d, 1'b0, i_led_user};
	assign o_led      = (led_ovr.overtake & led_ovr.state) | (~led_ovr.overtake & led_status);

endmodule

/* verilog/audio_mixer.sv */
/*
 * Stereo cross-mix and volume attenuation, two cycle latency.
 * audio_s selects signed samples and arithmetic shifts, else logical.
 * Mix and settings are taken in the same cycle as the samples.
 */
`include "sys_cfg.svh"

module audio_mixer (
	input  logic                              clk_sys,
	input  logic                              resetd,
	input  logic signed [sys_pkg::AUDIO_W-1:0] i_audio_l,
	input  logic signed [sys_pkg::AUDIO_W-1:0] i_audio_r,
	input  logic                              i_audio_s,
	input  logic [1:0]                        i_audio_mix,
	input  logic [`SYS_VOL_W-1:0]             i_vol_att,
	output logic [sys_pkg::AUDIO_W-1:0]       o_audio_l,
	output logic [sys_pkg::AUDIO_W-1:0]       o_audio_r
);
	import sys_pkg::*;

	logic [AUDIO_W-1:0]    mix_l;
	logic [AUDIO_W-1:0]    mix_r;
	logic                  sgn_d;
	logic [`SYS_VOL_W-1:0] vol_d;

	// Right shift, arithmetic for signed samples
	function automatic logic [AUDIO_W-1:0] shr(input logic [AUDIO_W-1:0] v,
		input logic [`SYS_VOL_W-2:0] n, input logic sgn);
		logic signed [AUDIO_W-1:0] sv;
		sv = v;
		if (sgn)
			shr = sv >>> n;
		else
			shr = v >> n;
	endfunction

	// S is the own channel, X the other one
	function automatic logic [AUDIO_W-1:0] mix(input logic [AUDIO_W-1:0] s,
		input logic [AUDIO_W-1:0] x, input logic [1:0] mode, input logic sgn);
		case (mode)
			2'd0:    mix = s;
			2'd1:    mix = s - shr(s, 3, sgn) + shr(x, 3, sgn);
			2'd2:    mix = s - shr(s, 2, sgn) + shr(x, 2, sgn);
			default: mix = shr(s, 1, sgn) + shr(x, 1, sgn);
		endcase
	endfunction

	// ==============================
	// Mix stage
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			mix_l <= '0;
			mix_r <= '0;
			sgn_d <= 1'b0;
			vol_d <= '0;
		end else begin
			mix_l <= mix(i_audio_l, i_audio_r, i_audio_mix, i_audio_s);
			mix_r <= mix(i_audio_r, i_audio_l, i_audio_mix, i_audio_s);
			sgn_d <= i_audio_s;
			vol_d <= i_vol_att;
		end
	end

	// ==============================
	// Attenuation stage
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (resetd || vol_d[`SYS_VOL_W-1]) begin
			o_audio_l <= '0;
			o_audio_r <= '0;
		end else begin
			o_audio_l <= shr(mix_l, vol_d[`SYS_VOL_W-2:0], sgn_d);
			o_audio_r <= shr(mix_r, vol_d[`SYS_VOL_W-2:0], sgn_d);
		end
	end

endmodule

/* verilog/sync_polarity_fix.sv */
/*
 * Turns a sync of either polarity into a positive-going one.
 * Needs two full sync periods of stable shape before the output is right.
 * Output is combinational from the raw input.
 */
`include "sys_cfg.svh"

module sync_polarity_fix (
	input  logic clk_sys,
	input  logic resetd,
	input  logic i_sync,
	output logic o_sync
);
	logic                       s1;
	logic                       s2;
	logic [`SYS_SYNC_CNT_W-1:0] cnt;
	logic [`SYS_SYNC_CNT_W-1:0] len_lo;
	logic [`SYS_SYNC_CNT_W-1:0] len_hi;
	logic                       pol;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			s1     <= 1'b0;
			s2     <= 1'b0;
			cnt    <= '0;
			len_lo <= '0;
			len_hi <= '0;
			pol    <= 1'b0;
		end else begin
			s1 <= i_sync;
			s2 <= s1;
			// Rising edge closes a low phase, falling edge a high one
			if (s1 & ~s2)
				len_lo <= cnt;
			if (~s1 & s2)
				len_hi <= cnt;
			if (s1 != s2)
				cnt <= '0;
			else if (~&cnt)
				cnt <= cnt + 1'b1;
			pol <= len_hi > len_lo;
		end
	end

	assign o_sync = i_sync ^ pol;

endmodule

/* verilog/vga_sync_out.sv */
/*
 * VGA output register stage, one cycle latency.
 * RGB is blanked outside DE and cut to the upper bits.
 * Syncs come out active low, separate or composite on HS.
 */
module vga_sync_out (
	input  logic                            clk_sys,
	input  logic                            resetd,
	input  logic                            i_csync,
	input  logic [sys_pkg::RGB_IN_W-1:0]    i_r,
	input  logic [sys_pkg::RGB_IN_W-1:0]    i_g,
	input  logic [sys_pkg::RGB_IN_W-1:0]    i_b,
	input  logic                            i_de,
	input  logic                            i_hs_fixed,
	input  logic                            i_vs_fixed,
	output logic [sys_pkg::RGB_OUT_W-1:0]   o_vga_r,
	output logic [sys_pkg::RGB_OUT_W-1:0]   o_vga_g,
	output logic [sys_pkg::RGB_OUT_W-1:0]   o_vga_b,
	output logic                            o_vga_hs,
	output logic                            o_vga_vs
);
	import sys_pkg::*;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_vga_r  <= '0;
			o_vga_g  <= '0;
			o_vga_b  <= '0;
			o_vga_hs <= 1'b1;
			o_vga_vs <= 1'b1;
		end else begin
			o_vga_r  <= i_de ? i_r[RGB_IN_W-1 -: RGB_OUT_W] : '0;
			o_vga_g  <= i_de ? i_g[RGB_IN_W-1 -: RGB_OUT_W] : '0;
			o_vga_b  <= i_de ? i_b[RGB_IN_W-1 -: RGB_OUT_W] : '0;
			// Composite mode carries both syncs on HS
			o_vga_vs <= i_csync ? 1'b1 : ~i_vs_fixed;
			o_vga_hs <= i_csync ? ~(i_vs_fixed ^ i_hs_fixed) : ~i_hs_fixed;
		end
	end

endmodule

/* verilog/sys_top.sv */
/*
 * System top, single clock domain clk_sys.
 * HPS command port, audio mix and VGA sync output of the core.
 * Raw core syncs may have either polarity.
 */
`include "sys_cfg.svh"

module sys_top (
	input  logic                                clk_sys,
	input  logic                                resetd,
	input  logic                                i_io_clk,
	input  logic                                i_io_uio,
	input  logic [`SYS_IO_W-1:0]                i_io_din,
	output logic                                o_io_ack,
	input  logic                                i_led_user,
	input  logic [1:0]                          i_led_power,
	input  logic [1:0]                          i_led_disk,
	output logic [7:0]                          o_led,
	input  logic signed [`SYS_AUDIO_W-1:0]      i_audio_l,
	input  logic signed [`SYS_AUDIO_W-1:0]      i_audio_r,
	input  logic                                i_audio_s,
	input  logic [1:0]                          i_audio_mix,
	output logic [`SYS_AUDIO_W-1:0]             o_audio_l,
	output logic [`SYS_AUDIO_W-1:0]             o_audio_r,
	input  logic [sys_pkg::RGB_IN_W-1:0]        i_r,
	input  logic [sys_pkg::RGB_IN_W-1:0]        i_g,
	input  logic [sys_pkg::RGB_IN_W-1:0]        i_b,
	input  logic                                i_de,
	input  logic                                i_hs,
	input  logic                                i_vs,
	output logic [sys_pkg::RGB_OUT_W-1:0]       o_vga_r,
	output logic [sys_pkg::RGB_OUT_W-1:0]       o_vga_g,
	output logic [sys_pkg::RGB_OUT_W-1:0]       o_vga_b,
	output logic                                o_vga_hs,
	output logic                                o_vga_vs
);
	logic [`SYS_VOL_W-1:0] vol_att;
	logic                  csync;
	logic                  hs_fixed;
	logic                  vs_fixed;

	hps_io_ctrl hps_io_i (
		.clk_sys(clk_sys), .resetd(resetd),
		.i_io_clk(i_io_clk), .i_io_uio(i_io_uio), .i_io_din(i_io_din),
		.i_led_user(i_led_user), .i_led_power(i_led_power), .i_led_disk(i_led_disk),
		.o_io_ack(o_io_ack), .o_vol_att(vol_att), .o_csync(csync), .o_led(o_led)
	);

	audio_mixer audio_i (
		.clk_sys(clk_sys), .resetd(resetd),
		.i_audio_l(i_audio_l), .i_audio_r(i_audio_r),
		.i_audio_s(i_audio_s), .i_audio_mix(i_audio_mix), .i_vol_att(vol_att),
		.o_audio_l(o_audio_l), .o_audio_r(o_audio_r)
	);

	// Horizontal and vertical polarity fixers
	sync_polarity_fix sync_h_i (.clk_sys(clk_sys), .resetd(resetd), .i_sync(i_hs), .o_sync(hs_fixed));
	sync_polarity_fix sync_v_i (.clk_sys(clk_sys), .resetd(resetd), .i_sync(i_vs), .o_sync(vs_fixed));

	vga_sync_out vga_i (
		.clk_sys(clk_sys), .resetd(resetd), .i_csync(csync),
		.i_r(i_r), .i_g(i_g), .i_b(i_b), .i_de(i_de),
		.i_hs_fixed(hs_fixed), .i_vs_fixed(vs_fixed),
		.o_vga_r(o_vga_r), .o_vga_g(o_vga_g), .o_vga_b(o_vga_b),
		.o_vga_hs(o_vga_hs), .o_vga_vs(o_vga_vs)
	);

endmodule

/* verif/sys_top_asserts.sv */
/*
 * Checker bound into sys_top.
 * Settings are tracked from the host side of the io port, so every check
 * pauses while an io word is in flight and a few cycles after it.
 * Sync checks start once the raw sync kept its shape for three periods.
 */
`include "sys_cfg.svh"

module sys_top_asserts (
	input logic        clk_sys, resetd,
	input logic        i_io_clk, i_io_uio, o_io_ack,
	input logic [15:0] i_io_din,
	input logic        i_led_user,
	input logic [1:0]  i_led_power, i_led_disk,
	input logic [7:0]  o_led,
	input logic [15:0] i_audio_l, i_audio_r, o_audio_l, o_audio_r,
	input logic        i_audio_s,
	input logic [1:0]  i_audio_mix,
	input logic [7:0]  i_r, i_g, i_b,
	input logic        i_de, i_hs, i_vs,
	input logic [5:0]  o_vga_r, o_vga_g, o_vga_b,
	input logic        o_vga_hs, o_vga_vs
);
	timeunit 1ns;
	timeprecision 100ps;

	logic        f_rst = 1'b0;
	logic        f_led = 1'b0;
	logic        f_aud = 1'b0;
	logic        f_sync = 1'b0;
	logic        f_rgb = 1'b0;
	logic        failed;
	logic        ack_q, has_cmd, csync, quiet;
	logic [7:0]  cmd;
	logic [15:0] led_w, exp_l1, exp_r1, exp_l2, exp_r2;
	logic [4:0]  vol;
	logic [3:0]  busy_sr;
	logic [1:0]  raw, prev, exp_fix, fix_q, ok_q, match;
	logic [15:0] run [2];
	logic [15:0] hi [2];
	logic [15:0] lo [2];
	logic [3:0]  settle [2];

	assign failed = f_rst | f_led | f_aud | f_sync | f_rgb;
	assign quiet  = !i_io_clk && !o_io_ack && busy_sr == 4'd0;
	assign raw    = {i_vs, i_hs};

	function automatic logic [7:0] exp_led(logic [15:0] w, logic u,
		logic [1:0] p, logic [1:0] d);
		logic [7:0] st;
		st    = 8'h00;
		st[4] = !(p[1] && !p[0]);
		st[2] = !(d[1] && !d[0]);
		st[0] = u;
		return (w[15:8] & w[7:0]) | (~w[15:8] & st);
	endfunction

	// Shift through a 32-bit int with sign or zero extension
	function automatic logic [15:0] shift_down(logic [15:0] v, int n, logic sgn);
		int w;
		w = sgn ? int'($signed(v)) : int'(v);
		w = w >>> n;
		return w[15:0];
	endfunction

	function automatic logic [15:0] exp_audio(logic [15:0] s, logic [15:0] x, logic [1:0] m,
		logic sgn, logic [4:0] v);
		logic [15:0] y;
		case (m)
			2'd0: y = s;
			2'd1: y = s - shift_down(s, 3, sgn) + shift_down(x, 3, sgn);
			2'd2: y = s - shift_down(s, 2, sgn) + shift_down(x, 2, sgn);
			default: y = shift_down(s, 1, sgn) + shift_down(x, 1, sgn);
		endcase
		return v[4] ? 16'd0 : shift_down(y, int'(v[3:0]), sgn);
	endfunction

	// ==============================
	// Reference models
	// ==============================
	always_comb begin
		for (int k = 0; k < 2; k++) begin
			match[k]   = prev[k] ? run[k] == hi[k] : run[k] == lo[k];
			exp_fix[k] = raw[k] == (hi[k] < lo[k]);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			{ack_q, has_cmd, csync, cmd, led_w, vol, busy_sr} <= '0;
			{exp_l1, exp_r1, exp_l2, exp_r2} <= '0;
			{prev, fix_q, ok_q} <= '0;
			for (int k = 0; k < 2; k++) begin
				run[k]    <= 16'd1;
				hi[k]     <= '0;
				lo[k]     <= '0;
				settle[k] <= '0;
			end
		end else begin
			ack_q   <= o_io_ack;
			busy_sr <= {busy_sr[2:0], i_io_clk | o_io_ack};
			// Word accepted when the ack rises
			if (!i_io_uio)
				has_cmd <= 1'b0;
			else if (o_io_ack && !ack_q) begin
				if (!has_cmd) begin
					has_cmd <= 1'b1;
					cmd     <= i_io_din[7:0];
				end else if (cmd == `SYS_CMD_CFG)
					csync <= i_io_din[`SYS_CSYNC_BIT];
				else if (cmd == `SYS_CMD_LED)
					led_w <= i_io_din;
				else if (cmd == `SYS_CMD_VOL)
					vol <= i_io_din[4:0];
			end
			exp_l1 <= exp_audio(i_audio_l, i_audio_r, i_audio_mix, i_audio_s, vol);
			exp_r1 <= exp_audio(i_audio_r, i_audio_l, i_audio_mix, i_audio_s, vol);
			exp_l2 <= exp_l1;
			exp_r2 <= exp_r1;
			for (int k = 0; k < 2; k++) begin
				prev[k]  <= raw[k];
				fix_q[k] <= exp_fix[k];
				ok_q[k]  <= settle[k] >= 4'd6 && hi[k] != lo[k];
				if (raw[k] != prev[k]) begin
					run[k] <= 16'd1;
					if (prev[k])
						hi[k] <= run[k];
					else
						lo[k] <= run[k];
					if (!match[k])
						settle[k] <= 4'd0;
					else if (~&settle[k])
						settle[k] <= settle[k] + 1'b1;
				end else if (~&run[k])
					run[k] <= run[k] + 1'b1;
			end
		end
	end

	// ==============================
	// Assertions
	// ==============================
	a_reset: assert property (@(posedge clk_sys)
		$past(resetd) |-> o_io_ack == 1'b0 && o_audio_l == '0 && o_audio_r == '0)
		else begin
			f_rst = 1'b1;
			$error("Error %0t: output not zero in reset", $time);
		end

	a_led: assert property (@(posedge clk_sys) disable iff (resetd)
		quiet |-> o_led == exp_led(led_w, i_led_user, i_led_power, i_led_disk))
		else begin
			f_led = 1'b1;
			$error("Error %0t: LED value wrong", $time);
		end

	a_audio: assert property (@(posedge clk_sys) disable iff (resetd)
		quiet && !$past(resetd) && !$past(resetd, 2)
		|-> o_audio_l == exp_l2 && o_audio_r == exp_r2)
		else begin
			f_aud = 1'b1;
			$error("Error %0t: audio sample wrong", $time);
		end

	a_sep_hs: assert property (@(posedge clk_sys) disable iff (resetd)
		quiet && !csync && ok_q[0] |-> o_vga_hs == !fix_q[0])
		else begin
			f_sync = 1'b1;
			$error("Error %0t: separate HS wrong", $time);
		end

	a_sep_vs: assert property (@(posedge clk_sys) disable iff (resetd)
		quiet && !csync && ok_q[1] |-> o_vga_vs == !fix_q[1])
		else begin
			f_sync = 1'b1;
			$error("Error %0t: separate VS wrong", $time);
		end

	a_csync: assert property (@(posedge clk_sys) disable iff (resetd)
		quiet && csync |-> o_vga_vs && (ok_q != 2'b11 || o_vga_hs == !(fix_q[0] ^ fix_q[1])))
		else begin
			f_sync = 1'b1;
			$error("Error %0t: composite sync wrong", $time);
		end

	a_rgb: assert property (@(posedge clk_sys) disable iff (resetd)
		!$past(resetd) |-> o_vga_r == ($past(i_de) ? $past(i_r[7:2]) : 6'd0)
		&& o_vga_g == ($past(i_de) ? $past(i_g[7:2]) : 6'd0)
		&& o_vga_b == ($past(i_de) ? $past(i_b[7:2]) : 6'd0))
		else begin
			f_rgb = 1'b1;
			$error("Error %0t: RGB output wrong", $time);
		end

endmodule

bind sys_top sys_top_asserts chk_i (.*);

/* verif/sys_top_tb.sv */
/*
 * Testbench for sys_top. The bound checker holds all checks.
 * Inputs change on the falling clock edge.
 * Random data comes from an xorshift.
 * The host holds io_din until io_ack is seen high.
 */
`include "sys_cfg.svh"

module sys_top_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 20;
	localparam int H_PER = 16;
	localparam int H_SHORT = 3;
	localparam int V_PER = 50;
	localparam int V_SHORT = 5;
	localparam int FRAME_CYC = 30;
	localparam int LED_WAIT = 200;
	localparam int VOL_WAIT = 120;
	localparam int SYNC_WAIT = 600;
	localparam int RUN_CYCLES = 16 + 7 * FRAME_CYC + LED_WAIT + 5 * VOL_WAIT + 4 * SYNC_WAIT + 10;

	logic               clk_sys = 1'b0;
	logic               resetd;
	logic               i_io_clk, i_io_uio, o_io_ack;
	logic [15:0]        i_io_din;
	logic               i_led_user;
	logic [1:0]         i_led_power, i_led_disk;
	logic [7:0]         o_led;
	logic signed [15:0] i_audio_l, i_audio_r;
	logic               i_audio_s;
	logic [1:0]         i_audio_mix;
	logic [15:0]        o_audio_l, o_audio_r;
	logic [7:0]         i_r, i_g, i_b;
	logic               i_de, i_hs, i_vs;
	logic [5:0]         o_vga_r, o_vga_g, o_vga_b;
	logic               o_vga_hs, o_vga_vs;
	logic [31:0]        rng = 32'd75682;
	logic [15:0]        led_word;
	logic               short_lvl;
	int                 hcnt, vcnt;
	logic [4:0]         vol_list [5] = '{5'd0, 5'd3, 5'd15, 5'h11, 5'd1};

	sys_top dut_i (.*);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	function automatic logic [31:0] xorshift(logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Random data and raw syncs
	always @(negedge clk_sys) begin
		rng = xorshift(rng);
		i_audio_l <= rng[15:0];
		i_audio_r <= rng[31:16];
		rng = xorshift(rng);
		{i_r, i_g, i_b, i_de, i_audio_s, i_audio_mix, i_led_user} <= rng[28:0];
		rng = xorshift(rng);
		{i_led_power, i_led_disk} <= rng[3:0];
		hcnt = (hcnt + 1) % H_PER;
		vcnt = (vcnt + 1) % V_PER;
		i_hs <= (hcnt < H_SHORT) ? short_lvl : ~short_lvl;
		i_vs <= (vcnt < V_SHORT) ? short_lvl : ~short_lvl;
	end

	task automatic host_write(input logic [15:0] w);
		@(negedge clk_sys);
		i_io_din = w;
		i_io_clk = 1'b1;
		do @(negedge clk_sys); while (!o_io_ack);
		i_io_clk = 1'b0;
		do @(negedge clk_sys); while (o_io_ack);
	endtask

	task automatic send_frame(input logic [7:0] cmd, input logic [15:0] data);
		@(negedge clk_sys);
		i_io_uio = 1'b1;
		host_write({8'h00, cmd});
		host_write(data);
		@(negedge clk_sys);
		i_io_uio = 1'b0;
	endtask

	// ==============================
	// Watchdog and failure monitor
	// ==============================
	initial begin
		#(2 * RUN_CYCLES * CLK_PERIOD);
		$display("TB FAILED");
		$fatal(1, "Watchdog timeout, the run did not finish in time");
	end

	always @(negedge clk_sys) begin
		if (dut_i.chk_i.failed) begin
			$display("TB FAILED");
			$fatal(1, "An assertion in the bound checker failed");
		end
	end

	initial begin
		{i_io_clk, i_io_uio, i_io_din} = '0;
		{i_led_user, i_led_power, i_led_disk} = '0;
		{i_audio_l, i_audio_r, i_audio_s, i_audio_mix} = '0;
		{i_r, i_g, i_b, i_de, i_hs, i_vs} = '0;
		short_lvl = 1'b0;
		hcnt = 0;
		vcnt = 0;
		// LED override word drawn before the clock runs
		rng = xorshift(rng);
		led_word = rng[15:0];
		resetd = 1'b1;
		repeat (16) @(posedge clk_sys);
		@(negedge clk_sys);
		resetd = 1'b0;
		send_frame(`SYS_CMD_LED, led_word);
		repeat (LED_WAIT) @(negedge clk_sys);
		// Volume steps, mute included
		for (int i = 0; i < 5; i++) begin
			send_frame(`SYS_CMD_VOL, {11'd0, vol_list[i]});
			repeat (VOL_WAIT) @(negedge clk_sys);
		end
		// Short low pulse, then short high pulse
		repeat (SYNC_WAIT) @(negedge clk_sys);
		short_lvl = 1'b1;
		repeat (SYNC_WAIT) @(negedge clk_sys);
		// Composite sync on
		send_frame(`SYS_CMD_CFG, 16'h0001 << `SYS_CSYNC_BIT);
		repeat (SYNC_WAIT) @(negedge clk_sys);
		short_lvl = 1'b0;
		repeat (SYNC_WAIT) @(negedge clk_sys);
		repeat (5) @(negedge clk_sys);
		if (dut_i.chk_i.failed) begin
			$display("TB FAILED");
			$fatal(1, "Checker reported a failure");
		end else begin
			$display("TB PASSED");
			$finish;
		end
	end

endmodule

/* compile.f */
+incdir+verilog
verilog/sys_pkg.sv
verilog/hps_io_ctrl.sv
verilog/audio_mixer.sv
verilog/sync_polarity_fix.sv
verilog/vga_sync_out.sv
verilog/sys_top.sv
verif/sys_top_asserts.sv
verif/sys_top_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the sys_top testbench with Verilator
cd "$(dirname "$0")" \
	&& verilator --binary --assert --timing -Wno-fatal \
		--top-module sys_top_tb -f compile.f -o sys_top_tb_sim \
	&& ./obj_dir/sys_top_tb_sim +verilator+error+limit+100 \
	|| exit 1
